// File: rtl/hubris_consts.svh
`ifndef HUBRIS_CONSTS_SVH
`define HUBRIS_CONSTS_SVH

// ----------------------------------------------------------------------
// datapath geometry
// ----------------------------------------------------------------------
// word width in bits
`define HUBRIS_XLEN 32
// x0..x31
`define HUBRIS_REG_COUNT 32

// addi x0, x0, 0
`define HUBRIS_NOP_INST 32'h0000_0013

// ----------------------------------------------------------------------
// memory-mapped output port
// ----------------------------------------------------------------------
// read returns free bytes in the output buffer
`define HUBRIS_OUT_AVAIL_ADDR 32'h8000_0000
// any store pushes the low byte of rs2
`define HUBRIS_OUT_BYTES_ADDR 32'h8000_0004
// output buffer depth in bytes
`define HUBRIS_OUT_DEPTH 32

`endif

// File: rtl/core_pkg.sv
package core_pkg;

    // major opcodes still decoded
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_t;

    // alu operations
    // pass_b forwards operand b untouched, used by lui
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLT    = 4'd2,
        ALU_XOR    = 4'd3,
        ALU_OR     = 4'd4,
        ALU_AND    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_PASS_B = 4'd8
    } alu_op_t;

    // where rd gets its value from
    typedef enum logic {
        WB_ALU     = 1'b0,
        WB_IO_READ = 1'b1
    } wb_src_t;

    // one instruction between decode and execute
    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic        reg_write;
        alu_op_t     alu_op;
        logic        alu_use_imm;
        wb_src_t     wb_src;
        logic        is_store;
        logic [31:0] imm;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
    } decoded_inst_t;

endpackage

// File: rtl/io_pkg.sv
package io_pkg;

    // kind of memory-mapped access made by one instruction
    typedef enum logic [1:0] {
        IO_NONE       = 2'd0,
        IO_READ_AVAIL = 2'd1,
        IO_WRITE_BYTE = 2'd2
    } io_access_t;

    // byte pushed into the output buffer
    // valid is a single-cycle strobe
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byte_push_t;

endpackage

// File: rtl/register_file.sv
`timescale 1ns/1ps
`include "hubris_consts.svh"

module register_file (
    input  logic                    clk,
    input  logic                    reset,
    // read ports, asynchronous
    input  logic [4:0]              rs1_addr,
    input  logic [4:0]              rs2_addr,
    output logic [`HUBRIS_XLEN-1:0] rs1_data,
    output logic [`HUBRIS_XLEN-1:0] rs2_data,
    // write port
    input  logic                    wr_en,
    input  logic [4:0]              wr_addr,
    input  logic [`HUBRIS_XLEN-1:0] wr_data
);

    logic [`HUBRIS_XLEN-1:0] regs [`HUBRIS_REG_COUNT];

    // all registers cleared on reset
    // x0 is never written, so it stays zero
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `HUBRIS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // combinational read
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // x0 survives writes aimed at it
    x0_stays_zero: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |=> regs[0] == '0
    ) else $error("x0 changed after a register write");

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`include "hubris_consts.svh"

module decode_stage
    import core_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    // instruction strobe
    input  logic                    inst_valid,
    input  logic [`HUBRIS_XLEN-1:0] inst,
    // register file read
    output logic [4:0]              rs1_addr,
    output logic [4:0]              rs2_addr,
    input  logic [`HUBRIS_XLEN-1:0] rs1_data,
    input  logic [`HUBRIS_XLEN-1:0] rs2_data,
    // write of the instruction now in execute
    input  logic                    bypass_en,
    input  logic [4:0]              bypass_addr,
    input  logic [`HUBRIS_XLEN-1:0] bypass_data,
    // registered towards execute
    output decoded_inst_t           decoded
);

    // ----------------------------------------------------------------------
    // control and immediate generation
    // ----------------------------------------------------------------------
    // operands are left at zero here
    function automatic decoded_inst_t decode_word(input logic [31:0] word);
        decoded_inst_t d;
        logic [2:0]    funct3;
        logic [6:0]    funct7;
        funct3 = word[14:12];
        funct7 = word[31:25];
        d = '0;
        d.rd = word[11:7];
        d.valid = 1'b1;
        d.wb_src = WB_ALU;
        d.alu_op = ALU_ADD;
        case (opcode_t'(word[6:0]))
            OP_IMM: begin
                // i-type immediate, shamt sits in its low bits
                d.imm = {{20{word[31]}}, word[31:20]};
                d.alu_use_imm = 1'b1;
                d.reg_write = 1'b1;
                case (funct3)
                    3'b000: d.alu_op = ALU_ADD;
                    3'b010: d.alu_op = ALU_SLT;
                    3'b100: d.alu_op = ALU_XOR;
                    3'b110: d.alu_op = ALU_OR;
                    3'b111: d.alu_op = ALU_AND;
                    3'b001: d.alu_op = ALU_SLL;
                    // srai is not kept
                    3'b101: d.alu_op = ALU_SRL;
                    default: d.valid = 1'b0;
                endcase
                if ((funct3 == 3'b001 || funct3 == 3'b101) && funct7 != 7'b0) begin
                    d.valid = 1'b0;
                end
            end
            OP: begin
                d.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: d.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: d.alu_op = ALU_SUB;
                    {7'b0000000, 3'b001}: d.alu_op = ALU_SLL;
                    {7'b0000000, 3'b010}: d.alu_op = ALU_SLT;
                    {7'b0000000, 3'b100}: d.alu_op = ALU_XOR;
                    {7'b0000000, 3'b101}: d.alu_op = ALU_SRL;
                    {7'b0000000, 3'b110}: d.alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: d.alu_op = ALU_AND;
                    default: d.valid = 1'b0;
                endcase
            end
            LUI: begin
                // u-type immediate straight through the alu
                d.imm = {word[31:12], 12'b0};
                d.alu_use_imm = 1'b1;
                d.alu_op = ALU_PASS_B;
                d.reg_write = 1'b1;
            end
            LOAD: begin
                // only lw, address = rs1 + imm
                d.imm = {{20{word[31]}}, word[31:20]};
                d.alu_use_imm = 1'b1;
                d.reg_write = 1'b1;
                d.wb_src = WB_IO_READ;
                d.valid = (funct3 == 3'b010);
            end
            STORE: begin
                // sb and sw, s-type immediate
                d.imm = {{20{word[31]}}, word[31:25], word[11:7]};
                d.alu_use_imm = 1'b1;
                d.is_store = 1'b1;
                d.valid = (funct3 == 3'b000 || funct3 == 3'b010);
            end
            default: d.valid = 1'b0;
        endcase
        // invalid entries must not write anything
        if (!d.valid) begin
            d.reg_write = 1'b0;
            d.is_store = 1'b0;
        end
        return d;
    endfunction

    // ----------------------------------------------------------------------
    // operand read with bypass
    // ----------------------------------------------------------------------
    decoded_inst_t next_entry;
    decoded_inst_t idle_entry;

    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    always_comb begin
        next_entry = decode_word(inst);
        // execute writes this cycle, regfile not yet updated
        if (bypass_en && bypass_addr == rs1_addr && rs1_addr != 5'd0) begin
            next_entry.rs1_data = bypass_data;
        end else begin
            next_entry.rs1_data = rs1_data;
        end
        if (bypass_en && bypass_addr == rs2_addr && rs2_addr != 5'd0) begin
            next_entry.rs2_data = bypass_data;
        end else begin
            next_entry.rs2_data = rs2_data;
        end
    end

    // nop bubble, never valid
    always_comb begin
        idle_entry = decode_word(`HUBRIS_NOP_INST);
        idle_entry.valid = 1'b0;
        idle_entry.reg_write = 1'b0;
    end

    // decode register
    always_ff @(posedge clk) begin
        if (reset || !inst_valid) begin
            decoded <= idle_entry;
        end else begin
            decoded <= next_entry;
        end
    end

    // only a strobed instruction reaches execute
    valid_follows_strobe: assert property (
        @(posedge clk) disable iff (reset)
        decoded.valid |-> $past(inst_valid)
    ) else $error("decoded entry valid without an instruction strobe");

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps
`include "hubris_consts.svh"

module execute_stage
    import core_pkg::*;
    import io_pkg::*;
(
    input  decoded_inst_t           decoded,
    // register write, also fed back to decode
    output logic                    wr_en,
    output logic [4:0]              wr_addr,
    output logic [`HUBRIS_XLEN-1:0] wr_data,
    // output buffer side
    output byte_push_t              push,
    input  logic [`HUBRIS_XLEN-1:0] out_avail
);

    logic [`HUBRIS_XLEN-1:0] op_a;
    logic [`HUBRIS_XLEN-1:0] op_b;
    logic [`HUBRIS_XLEN-1:0] alu_result;
    io_access_t              access;

    // ----------------------------------------------------------------------
    // alu
    // ----------------------------------------------------------------------
    assign op_a = decoded.rs1_data;
    // immediate for op-imm, lui and address math
    assign op_b = decoded.alu_use_imm ? decoded.imm : decoded.rs2_data;

    always_comb begin
        case (decoded.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_SLT:    alu_result = `HUBRIS_XLEN'($signed(op_a) < $signed(op_b));
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_AND:    alu_result = op_a & op_b;
            // shift amount from the low five bits
            ALU_SLL:    alu_result = op_a << op_b[4:0];
            ALU_SRL:    alu_result = op_a >> op_b[4:0];
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // memory-mapped access
    // ----------------------------------------------------------------------
    // alu result is the address for loads and stores
    always_comb begin
        access = IO_NONE;
        if (decoded.valid && decoded.is_store &&
            alu_result == `HUBRIS_OUT_BYTES_ADDR) begin
            access = IO_WRITE_BYTE;
        end else if (decoded.valid && decoded.wb_src == WB_IO_READ &&
                     alu_result == `HUBRIS_OUT_AVAIL_ADDR) begin
            access = IO_READ_AVAIL;
        end
    end

    // low byte of rs2, whatever the store width
    assign push.valid = (access == IO_WRITE_BYTE);
    assign push.data  = decoded.rs2_data[7:0];

    // ----------------------------------------------------------------------
    // write-back
    // ----------------------------------------------------------------------
    assign wr_en   = decoded.valid && decoded.reg_write;
    assign wr_addr = decoded.rd;

    // loads from other addresses read zero
    always_comb begin
        if (decoded.wb_src == WB_ALU) begin
            wr_data = alu_result;
        end else if (access == IO_READ_AVAIL) begin
            wr_data = out_avail;
        end else begin
            wr_data = '0;
        end
    end

endmodule

// File: rtl/output_byte_buffer.sv
`timescale 1ns/1ps
`include "hubris_consts.svh"

module output_byte_buffer
    import io_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    // from the core
    input  byte_push_t              push,
    // external drain
    input  logic                    pop,
    output logic [7:0]              head_data,
    output logic [`HUBRIS_XLEN-1:0] free_count
);

    localparam int PTR_W = $clog2(`HUBRIS_OUT_DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(`HUBRIS_OUT_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(`HUBRIS_OUT_DEPTH);

    logic [7:0]       mem [`HUBRIS_OUT_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // full drops the push, empty ignores the pop
    assign do_push = push.valid && count != FULL_COUNT;
    assign do_pop  = pop && count != '0;

    // ----------------------------------------------------------------------
    // storage
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push.data;
        end
    end

    // oldest byte, garbage while empty
    assign head_data = mem[rd_ptr];

    // ----------------------------------------------------------------------
    // pointers and occupancy
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            // both at once leaves count unchanged
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // depth minus occupancy
    assign free_count = `HUBRIS_XLEN'(`HUBRIS_OUT_DEPTH) - `HUBRIS_XLEN'(count);

    count_in_range: assert property (
        @(posedge clk) disable iff (reset)
        count <= FULL_COUNT
    ) else $error("output buffer occupancy above depth");

endmodule

// File: rtl/hubris_lite.sv
`timescale 1ns/1ps

module hubris_lite
    import core_pkg::*;
    import io_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    // instruction strobe
    input  logic        inst_valid,
    input  logic [31:0] inst,
    // output byte drain
    input  logic        io_output_en,
    output logic [7:0]  io_output_data,
    output logic [31:0] io_buffer_size_avai
);

    // ----------------------------------------------------------------------
    // interconnect
    // ----------------------------------------------------------------------
    logic [4:0]    rs1_addr;
    logic [4:0]    rs2_addr;
    logic [31:0]   rs1_data;
    logic [31:0]   rs2_data;
    decoded_inst_t decoded;
    // execute write, shared by regfile and bypass
    logic          wr_en;
    logic [4:0]    wr_addr;
    logic [31:0]   wr_data;
    byte_push_t    push;

    decode_stage decode_i (
        .clk         (clk),
        .reset       (reset),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .bypass_en   (wr_en),
        .bypass_addr (wr_addr),
        .bypass_data (wr_data),
        .decoded     (decoded)
    );

    register_file regfile_i (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    execute_stage execute_i (
        .decoded   (decoded),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .push      (push),
        .out_avail (io_buffer_size_avai)
    );

    // free count goes both to the lw path and outside
    output_byte_buffer out_buf_i (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .pop        (io_output_en),
        .head_data  (io_output_data),
        .free_count (io_buffer_size_avai)
    );

endmodule

// File: sim/tb_hubris_lite.sv
`timescale 1ns/1ps
`include "hubris_consts.svh"

module tb_hubris_lite;

    logic        clk;
    logic        reset;
    logic        inst_valid;
    logic [31:0] inst;
    logic        io_output_en;
    logic [7:0]  io_output_data;
    logic [31:0] io_buffer_size_avai;

    // model state
    logic [31:0] model_regs [32];
    logic [7:0]  exp_bytes [$];
    int          seed = 31860;
    logic        drain_on = 1'b1;
    logic [4:0]  prev_rd;

    hubris_lite dut_i (
        .clk                 (clk),
        .reset               (reset),
        .inst_valid          (inst_valid),
        .inst                (inst),
        .io_output_en        (io_output_en),
        .io_output_data      (io_output_data),
        .io_buffer_size_avai (io_buffer_size_avai)
    );

    always #20 clk = ~clk;

    // ----------------------------------------------------------------------
    // instruction encoders
    // ----------------------------------------------------------------------
    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_u(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_lw(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    // random op-imm, op or lui
    function automatic logic [31:0] rand_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
        logic [2:0]  imm_f3 [7];
        logic [9:0]  op_fn [8];
        int          sel;
        logic [11:0] imm;
        imm_f3 = '{3'd0, 3'd2, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5};
        // {funct7, funct3} of add sub sll slt xor srl or and
        op_fn = '{10'h000, 10'h100, 10'h001, 10'h002, 10'h004, 10'h005, 10'h006, 10'h007};
        sel = $unsigned($random(seed)) % 16;
        imm = $random(seed);
        if (sel < 7) begin
            // shifts keep funct7 zero
            if (imm_f3[sel] == 3'd1 || imm_f3[sel] == 3'd5) begin
                imm = {7'b0, imm[4:0]};
            end
            return enc_i(imm_f3[sel], rd, rs1, imm);
        end else if (sel < 15) begin
            return enc_r(op_fn[sel-7][9:3], op_fn[sel-7][2:0], rd, rs1, rs2);
        end else begin
            return enc_u(rd, $random(seed));
        end
    endfunction

    // ----------------------------------------------------------------------
    // reference model, one instruction in program order
    // ----------------------------------------------------------------------
    function automatic void model_exec(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] res;
        logic        has_res;
        a = model_regs[w[19:15]];
        b = model_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        res = '0;
        has_res = 1'b0;
        case (w[6:0])
            7'b0010011: begin
                has_res = 1'b1;
                case (w[14:12])
                    3'd0: res = a + imm_i;
                    3'd2: res = ($signed(a) < $signed(imm_i)) ? 32'd1 : 32'd0;
                    3'd4: res = a ^ imm_i;
                    3'd6: res = a | imm_i;
                    3'd7: res = a & imm_i;
                    3'd1: res = a << imm_i[4:0];
                    default: res = a >> imm_i[4:0];
                endcase
                // srai and malformed shifts do nothing
                if ((w[14:12] == 3'd1 || w[14:12] == 3'd5) && w[31:25] != 7'd0) begin
                    has_res = 1'b0;
                end
            end
            7'b0110011: begin
                has_res = 1'b1;
                case ({w[31:25], w[14:12]})
                    10'h000: res = a + b;
                    10'h100: res = a - b;
                    10'h001: res = a << b[4:0];
                    10'h002: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    10'h004: res = a ^ b;
                    10'h005: res = a >> b[4:0];
                    10'h006: res = a | b;
                    10'h007: res = a & b;
                    default: has_res = 1'b0;
                endcase
            end
            7'b0110111: begin
                has_res = 1'b1;
                res = {w[31:12], 12'b0};
            end
            7'b0000011: begin
                // free count, any other address reads zero
                has_res = (w[14:12] == 3'b010);
                if (a + imm_i == `HUBRIS_OUT_AVAIL_ADDR) begin
                    res = `HUBRIS_OUT_DEPTH - exp_bytes.size();
                end
            end
            7'b0100011: begin
                if ((w[14:12] == 3'd0 || w[14:12] == 3'd2) &&
                    a + imm_s == `HUBRIS_OUT_BYTES_ADDR &&
                    exp_bytes.size() < `HUBRIS_OUT_DEPTH) begin
                    exp_bytes.push_back(b[7:0]);
                end
            end
            default: has_res = 1'b0;
        endcase
        if (has_res && w[11:7] != 5'd0) begin
            model_regs[w[11:7]] = res;
        end
    endfunction

    // ----------------------------------------------------------------------
    // checks and stimulus helpers
    // ----------------------------------------------------------------------
    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s, got %0h, expected %0h",
                     $time, msg, actual, expected);
            $display("Test failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    // one strobe per cycle, back-to-back when called in a row
    task automatic issue(input logic [31:0] w);
        @(posedge clk);
        #2;
        inst_valid = 1'b1;
        inst = w;
        model_exec(w);
    endtask

    task automatic end_burst();
        @(posedge clk);
        #2;
        inst_valid = 1'b0;
        inst = `HUBRIS_NOP_INST;
    endtask

    // sb or sw of a register to the output port, base in x31
    task automatic store_reg(input logic [4:0] r);
        issue(enc_s(($random(seed) & 1) ? 3'd2 : 3'd0, 5'd31, r, 12'd4));
    endtask

    task automatic wait_free(input logic [31:0] target, input string what);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        while (io_buffer_size_avai != target) begin
            if (cycles == 400) begin
                abort_run($sformatf("timeout: free count stuck at %0d while %s",
                                    io_buffer_size_avai, what));
            end else begin
                cycles++;
                @(posedge clk);
                #1;
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // drain and compare
    // ----------------------------------------------------------------------
    initial begin : drain
        logic [7:0] want;
        forever begin
            @(posedge clk);
            #2;
            io_output_en = 1'b0;
            if (!reset && drain_on && io_buffer_size_avai < `HUBRIS_OUT_DEPTH) begin
                if (exp_bytes.size() == 0) begin
                    abort_run("the output buffer holds a byte that no store should have pushed");
                end else begin
                    want = exp_bytes.pop_front();
                    check({24'b0, io_output_data}, {24'b0, want}, "output byte");
                    io_output_en = 1'b1;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        reset = 1'b1;
        inst_valid = 1'b0;
        inst = `HUBRIS_NOP_INST;
        io_output_en = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        check(io_buffer_size_avai, 32'd32, "free count after reset");

        // x31 holds the i/o base
        issue(enc_u(5'd31, 20'h80000));
        prev_rd = 5'd1;
        for (int n = 0; n < 60; n++) begin
            logic [4:0] rd;
            logic [4:0] rs1;
            rd = 5'd1 + ($unsigned($random(seed)) % 30);
            // every other op reads the previous result
            rs1 = (n % 2 == 0) ? prev_rd : ($unsigned($random(seed)) % 31);
            issue(rand_inst(rd, rs1, $unsigned($random(seed)) % 31));
            store_reg(rd);
            prev_rd = rd;
        end

        // writes to x0 are lost
        issue(enc_i(3'd0, 5'd0, 5'd5, 12'h7ff));
        store_reg(5'd0);
        end_burst();
        wait_free(32'd32, "draining random results");
        check(exp_bytes.size(), 0, "bytes still expected after drain");

        // free count read back with the drain stopped
        drain_on = 1'b0;
        for (int n = 0; n < 5; n++) begin
            store_reg(5'd1 + n);
        end
        issue(enc_lw(5'd9, 5'd31, 12'd0));
        store_reg(5'd9);
        end_burst();
        drain_on = 1'b1;
        wait_free(32'd32, "draining the free count");

        // overflow, 40 pushes into 32 slots
        drain_on = 1'b0;
        for (int n = 0; n < 40; n++) begin
            issue(enc_i(3'd0, 5'd10, 5'd0, 12'(n + 8'h40)));
            store_reg(5'd10);
        end
        end_burst();
        wait_free(32'd0, "filling the buffer");
        drain_on = 1'b1;
        wait_free(32'd32, "draining a full buffer");
        check(exp_bytes.size(), 0, "bytes still expected after full drain");

        // ignored stores, unsupported opcodes, lw elsewhere
        issue(enc_s(3'd2, 5'd31, 5'd5, 12'd8));
        issue({20'hfffff, 5'd5, 7'b0010111});
        issue(enc_i(3'd5, 5'd6, 5'd6, 12'h401));
        issue({20'h00010, 5'd7, 7'b1101111});
        issue(enc_lw(5'd8, 5'd31, 12'd12));
        for (int r = 5; r <= 8; r++) begin
            store_reg(r);
        end
        end_burst();
        wait_free(32'd32, "draining after ignored instructions");
        check(exp_bytes.size(), 0, "bytes still expected at the end");

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: all.f
+incdir+rtl
rtl/core_pkg.sv
rtl/io_pkg.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/output_byte_buffer.sv
rtl/hubris_lite.sv
sim/tb_hubris_lite.sv
